//--- design/cache_geom_pkg.sv
package cache_geom_pkg;

  localparam int addr_bits = 32;
  localparam int line_words = 4;
  localparam int byte_bits = 2;  // byte offset inside a word
  localparam int word_sel_bits = $clog2(line_words);
  localparam int offset_bits = byte_bits + word_sel_bits;

  // 256 sets unless the top level says otherwise
  localparam int default_set_bits = 8;
  localparam int default_tag_bits = addr_bits - default_set_bits - offset_bits;

  typedef logic [31:0] word_t;
  typedef logic [3:0] strb_t;  // one strobe per byte of word_t

  // word 0 sits in the low bits, same order as memory
  typedef word_t [line_words-1:0] line_t;

  // address fields at the default geometry
  typedef logic [default_set_bits-1:0] index_t;
  typedef logic [default_tag_bits-1:0] tag_t;
  typedef logic [word_sel_bits-1:0] word_sel_t;

endpackage

//--- design/cache_bus_pkg.sv
package cache_bus_pkg;
  import cache_geom_pkg::*;

  // cpu side request, word aligned
  typedef struct packed {
    logic we;  // store
    logic [addr_bits-1:0] addr;
    strb_t wstrb;
    word_t wdata;
  } cpu_req_t;

  // memory side request, always a whole line
  typedef struct packed {
    logic we;  // write-back of a victim
    logic [addr_bits-1:0] addr;  // offset bits are zero
    line_t line;
  } mem_req_t;

  // one write into the tag and data arrays
  typedef struct packed {
    logic en;
    logic way;
    index_t index;
    tag_t tag;
    line_t line;
    logic dirty;
  } arr_wr_t;

endpackage

//--- design/sync_ram.sv
module sync_ram #(
  parameter int depth_bits = 8,
  parameter type entry_t = logic [31:0]
) (
  input  logic                  clk,
  input  logic                  en,
  input  logic                  we,
  input  logic [depth_bits-1:0] addr,
  input  entry_t                din,
  output entry_t                dout
);

  entry_t mem [2**depth_bits];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= din;
        dout <= din;  // write-first, new entry visible next cycle
      end else begin
        dout <= mem[addr];
      end
    end
  end

endmodule

//--- design/cpu_front.sv
module cpu_front
  import cache_geom_pkg::*;
  import cache_bus_pkg::*;
#(
  parameter int set_bits = default_set_bits
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_valid,
  input  logic     req_ready,
  input  cpu_req_t req,
  input  logic     respond,
  input  line_t    hit_line,
  output logic [set_bits-1:0] read_index,
  output logic [set_bits-1:0] cur_index,
  output logic [addr_bits-set_bits-offset_bits-1:0] cur_tag,
  output logic     cur_we,
  output line_t    store_line,
  output logic     resp_valid,
  output word_t    rdata
);

  localparam int tag_bits = addr_bits - set_bits - offset_bits;

  cpu_req_t req_q;
  logic accept;
  word_sel_t word_sel;

  assign accept = req_valid && req_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_q <= '0;
    end else if (accept) begin
      req_q <= req;
    end
  end

  // the rams sample this index, so a new request must go straight through
  assign read_index = accept ? req.addr[offset_bits +: set_bits]
                             : req_q.addr[offset_bits +: set_bits];

  assign cur_index = req_q.addr[offset_bits +: set_bits];
  assign cur_tag   = req_q.addr[addr_bits-1 -: tag_bits];
  assign cur_we    = req_q.we;
  assign word_sel  = req_q.addr[byte_bits +: word_sel_bits];

  // load word, only in the response cycle
  assign resp_valid = respond;
  assign rdata = (respond && !req_q.we) ? hit_line[word_sel] : '0;

  // patch the strobed bytes into the hit line
  always_comb begin
    store_line = hit_line;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (req_q.wstrb[b]) begin
        store_line[word_sel][8*b +: 8] = req_q.wdata[8*b +: 8];
      end
    end
  end

  // the controller answers only while it is busy with the held request
  a_no_resp_when_ready: assert property (
    @(posedge clk) disable iff (!rst_n) !(respond && req_ready)
  );

endmodule

//--- design/set_store.sv
module set_store
  import cache_geom_pkg::*;
  import cache_bus_pkg::*;
#(
  parameter int set_bits = default_set_bits
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic [set_bits-1:0] read_index,
  input  logic [addr_bits-set_bits-offset_bits-1:0] cur_tag,
  input  arr_wr_t wr,
  output logic    hit,
  output logic    hit_way,
  output line_t   hit_line,
  output logic    victim_dirty,
  output logic [addr_bits-set_bits-offset_bits-1:0] victim_tag,
  output line_t   victim_line
);

  localparam int tag_bits = addr_bits - set_bits - offset_bits;
  localparam int sets = 2**set_bits;

  typedef logic [tag_bits-1:0] way_tag_t;

  logic [1:0][sets-1:0] valid_q;
  logic [1:0][sets-1:0] dirty_q;
  logic [sets-1:0] lru_q;  // way to replace next
  logic [set_bits-1:0] rd_idx_q;  // set held on the ram outputs

  way_tag_t tag_q [2];
  line_t line_q [2];
  logic [1:0] way_hit;
  logic victim_way;

  for (genvar w = 0; w < 2; w++) begin : g_way
    logic sel_wr;
    logic [set_bits-1:0] ram_addr;

    assign sel_wr = wr.en && (wr.way == 1'(w));
    assign ram_addr = sel_wr ? wr.index : read_index;

    sync_ram #(.depth_bits(set_bits), .entry_t(way_tag_t)) tag_ram (
      .clk, .en(1'b1), .we(sel_wr), .addr(ram_addr), .din(wr.tag), .dout(tag_q[w])
    );

    sync_ram #(.depth_bits(set_bits), .entry_t(line_t)) data_ram (
      .clk, .en(1'b1), .we(sel_wr), .addr(ram_addr), .din(wr.line), .dout(line_q[w])
    );

    assign way_hit[w] = valid_q[w][rd_idx_q] && (tag_q[w] == cur_tag);
  end

  assign victim_way = lru_q[rd_idx_q];
  assign hit = |way_hit;
  // on a miss this names the victim, which is where the refill goes
  assign hit_way = hit ? way_hit[1] : victim_way;
  assign hit_line = line_q[way_hit[1]];

  assign victim_dirty = valid_q[victim_way][rd_idx_q] && dirty_q[victim_way][rd_idx_q];
  assign victim_tag   = tag_q[victim_way];
  assign victim_line  = line_q[victim_way];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q  <= '0;
      dirty_q  <= '0;
      lru_q    <= '0;  // way 0 goes first
      rd_idx_q <= '0;
    end else begin
      rd_idx_q <= read_index;
      if (wr.en) begin
        valid_q[wr.way][wr.index] <= 1'b1;
        dirty_q[wr.way][wr.index] <= wr.dirty;
        lru_q[wr.index] <= ~wr.way;
      end else if (hit) begin
        lru_q[rd_idx_q] <= ~hit_way;
      end
    end
  end

  // a write takes the ram port, so no other set may be looked up meanwhile
  a_wr_same_set: assert property (
    @(posedge clk) disable iff (!rst_n) wr.en |-> (read_index == wr.index)
  );

endmodule

//--- design/cache_ctrl.sv
module cache_ctrl
  import cache_geom_pkg::*;
  import cache_bus_pkg::*;
#(
  parameter int set_bits = default_set_bits
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_valid,
  output logic     req_ready,
  input  logic     cur_we,
  input  logic [set_bits-1:0] cur_index,
  input  logic [addr_bits-set_bits-offset_bits-1:0] cur_tag,
  input  logic     hit,
  input  logic     hit_way,
  input  line_t    store_line,
  input  logic     victim_dirty,
  input  logic [addr_bits-set_bits-offset_bits-1:0] victim_tag,
  input  line_t    victim_line,
  output logic     respond,
  output arr_wr_t  wr,
  output logic     mem_valid,
  output mem_req_t mem_req,
  input  logic     mem_ack,
  input  line_t    mem_rdata
);

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    STORE,
    WRITEBACK,
    REFILL
  } state_t;

  state_t state, next_state;

  logic mem_valid_q;
  mem_req_t mem_req_q;
  mem_req_t wb_req;
  mem_req_t fill_req;
  logic done;  // transfer completes this cycle
  logic miss;

  assign done = mem_valid_q && mem_ack;
  assign miss = (state == LOOKUP) && !hit;

  assign wb_req = '{we: 1'b1,
                    addr: {victim_tag, cur_index, {offset_bits{1'b0}}},
                    line: victim_line};
  assign fill_req = '{we: 1'b0,
                      addr: {cur_tag, cur_index, {offset_bits{1'b0}}},
                      line: '0};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (req_valid) begin
          next_state = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit) begin
          next_state = cur_we ? STORE : IDLE;
        end else begin
          next_state = victim_dirty ? WRITEBACK : REFILL;
        end
      end
      STORE: next_state = IDLE;
      WRITEBACK: begin
        if (done) begin
          next_state = REFILL;
        end
      end
      REFILL: begin
        if (done) begin
          next_state = LOOKUP;  // look again, now it hits
        end
      end
      default: next_state = IDLE;
    endcase
  end

  assign req_ready = (state == IDLE);
  assign respond = (state == LOOKUP) && hit;

  // mem_valid drops for a cycle between write-back and refill
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_valid_q <= 1'b0;
    end else if (done) begin
      mem_valid_q <= 1'b0;
    end else if (miss || state == REFILL) begin
      mem_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (miss) begin
      mem_req_q <= victim_dirty ? wb_req : fill_req;
    end else if (state == WRITEBACK && done) begin
      mem_req_q <= fill_req;
    end
  end

  assign mem_valid = mem_valid_q;
  assign mem_req = mem_req_q;

  // array writes: merged store line, or the refilled line
  always_comb begin
    wr = '0;
    wr.way = hit_way;
    wr.index = cur_index;
    wr.tag = cur_tag;
    if (state == STORE) begin
      wr.en = 1'b1;
      wr.line = store_line;
      wr.dirty = 1'b1;
    end else if (state == REFILL && done) begin
      wr.en = 1'b1;
      wr.line = mem_rdata;
      wr.dirty = 1'b0;  // clean copy of memory
    end
  end

  a_mem_req_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (mem_valid && !mem_ack) |=> (mem_valid && $stable(mem_req))
  );

endmodule

//--- design/dcache_top.sv
module dcache_top
  import cache_geom_pkg::*;
  import cache_bus_pkg::*;
#(
  parameter int set_bits = default_set_bits
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_valid,
  input  cpu_req_t req,
  output logic     req_ready,
  output logic     resp_valid,
  output word_t    rdata,
  output logic     mem_valid,
  output mem_req_t mem_req,
  input  logic     mem_ack,
  input  line_t    mem_rdata
);

  localparam int tag_bits = addr_bits - set_bits - offset_bits;

  logic [set_bits-1:0] read_index;
  logic [set_bits-1:0] cur_index;
  logic [tag_bits-1:0] cur_tag;
  logic cur_we;
  line_t store_line;
  logic respond;

  logic hit;
  logic hit_way;
  line_t hit_line;
  logic victim_dirty;
  logic [tag_bits-1:0] victim_tag;
  line_t victim_line;
  arr_wr_t wr;

  cpu_front #(.set_bits(set_bits)) front_i (
    .clk, .rst_n, .req_valid, .req_ready, .req, .respond, .hit_line,
    .read_index, .cur_index, .cur_tag, .cur_we, .store_line, .resp_valid, .rdata
  );

  set_store #(.set_bits(set_bits)) store_i (
    .clk, .rst_n, .read_index, .cur_tag, .wr,
    .hit, .hit_way, .hit_line, .victim_dirty, .victim_tag, .victim_line
  );

  cache_ctrl #(.set_bits(set_bits)) ctrl_i (
    .clk, .rst_n, .req_valid, .req_ready, .cur_we, .cur_index, .cur_tag,
    .hit, .hit_way, .store_line, .victim_dirty, .victim_tag, .victim_line,
    .respond, .wr, .mem_valid, .mem_req, .mem_ack, .mem_rdata
  );

endmodule

//--- test/mem_model.sv
module mem_model
  import cache_geom_pkg::*;
  import cache_bus_pkg::*;
#(
  parameter logic [31:0] fill_key = 32'h0,
  parameter int seed_init = 1
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     mem_valid,
  input  mem_req_t mem_req,
  output logic     mem_ack,
  output line_t    mem_rdata
);
  timeunit 1ns;
  timeprecision 100ps;

  word_t written [logic [29:0]];  // words that came back by write-back
  integer seed;
  int delay;
  mem_req_t cur;

  // untouched words follow the fill rule on the word address
  function automatic word_t read_word(input logic [29:0] wa);
    if (written.exists(wa)) begin
      return written[wa];
    end else begin
      return {2'b00, wa} ^ fill_key;
    end
  endfunction

  initial begin
    seed = seed_init;
    mem_ack = 1'b0;
    mem_rdata = '0;
    forever begin
      @(posedge clk);
      #1;
      if (rst_n && mem_valid) begin
        cur = mem_req;
        delay = 1 + ($random(seed) & 3);  // 1 to 4 cycles
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        for (int w = 0; w < line_words; w++) begin
          if (cur.we) begin
            written[cur.addr[31:2] + 30'(w)] = cur.line[w];
          end else begin
            mem_rdata[w] = read_word(cur.addr[31:2] + 30'(w));
          end
        end
        mem_ack = 1'b1;
        @(posedge clk);
        #1;
        mem_ack = 1'b0;
        mem_rdata = '0;
      end
    end
  end

endmodule

//--- test/dcache_tb.sv
module dcache_tb
  import cache_geom_pkg::*;
  import cache_bus_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int period = 40;
  localparam logic [31:0] seed_init = 32'hc332;
  localparam logic [31:0] fill_key = 32'h5a3c_96e1;
  localparam logic [31:0] base_addr = 32'h0002_4000;
  localparam int tag_shift = offset_bits + default_set_bits;
  localparam int num_txn = 400;
  localparam int worst_cycles = 24;  // dirty miss, slow memory, store cycle
  localparam int watchdog_ns = (num_txn + 16) * worst_cycles * period;

  logic clk = 1'b0;
  logic rst_n;
  logic req_valid;
  cpu_req_t req;
  logic req_ready;
  logic resp_valid;
  word_t rdata;
  logic mem_valid;
  mem_req_t mem_req;
  logic mem_ack;
  line_t mem_rdata;

  integer seed;
  word_t model [64];  // 4 tags x 4 sets x 4 words
  logic touched [16];
  int prev_line = -1;
  logic xfer_active = 1'b0;
  mem_req_t start_req;
  int reads_total = 0;
  int mem_cycles_total = 0;
  logic [31:0] last_read_addr;
  int reads_at_start = 0;
  int mem_at_start = 0;

  dcache_top #(.set_bits(default_set_bits)) dcache_top_i (
    .clk, .rst_n, .req_valid, .req, .req_ready, .resp_valid, .rdata,
    .mem_valid, .mem_req, .mem_ack, .mem_rdata
  );

  mem_model #(.fill_key(fill_key), .seed_init(seed_init)) mem_i (
    .clk, .rst_n, .mem_valid, .mem_req, .mem_ack, .mem_rdata
  );

  always #(period / 2) clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got %0h expected %0h", name, got, exp);
      abort_run("value mismatch");
    end
  endtask

  function automatic int slot(input logic [31:0] addr);
    return int'({addr[tag_shift+1:tag_shift], addr[5:4], addr[3:2]});
  endfunction

  function automatic logic [31:0] make_addr(input int t, input int s, input int w);
    return base_addr | 32'(t << tag_shift) | 32'(s << offset_bits) | 32'(w << byte_bits);
  endfunction

  function automatic line_t model_line(input logic [31:0] line_addr);
    line_t l;
    for (int w = 0; w < line_words; w++) begin
      l[w] = model[slot(line_addr + 32'(4 * w))];
    end
    return l;
  endfunction

  task automatic check_quiet_outputs();
    check_eq("req_ready", 128'(req_ready), 128'(1));
    check_eq("resp_valid", 128'(resp_valid), 128'(0));
    check_eq("mem_valid", 128'(mem_valid), 128'(0));
  endtask

  // called and returns a little after a rising edge
  task automatic run_request(input logic we, input logic [31:0] addr, input strb_t strb,
                             input word_t wdata);
    int lat;
    int line_no;
    word_t got;
    word_t exp;
    line_no = slot(addr) >> 2;
    exp = we ? '0 : model[slot(addr)];
    reads_at_start = reads_total;
    mem_at_start = mem_cycles_total;
    req_valid = 1'b1;
    req.we = we;
    req.addr = addr;
    req.wstrb = strb;
    req.wdata = wdata;
    while (!req_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);  // accepted here
    #1;
    req_valid = 1'b0;
    req = '0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
      check_eq("req_ready", 128'(req_ready), 128'(0));
    end while (!resp_valid);
    got = rdata;
    @(posedge clk);
    #1;
    check_eq("rdata", 128'(got), 128'(exp));
    check_eq("resp_valid", 128'(resp_valid), 128'(0));  // single cycle pulse
    check_eq("req_ready", 128'(req_ready), 128'(!we));  // a store spends one STORE cycle
    if (!touched[line_no]) begin
      if (reads_total - reads_at_start != 1) begin
        abort_run("first use of a line did not read it from memory exactly once");
      end
      check_eq("mem_req.addr (refill)", 128'(last_read_addr), 128'(addr & ~32'h0000_000f));
    end
    if (line_no == prev_line) begin  // line was just used, must hit
      check_eq("resp_valid latency", 128'(lat), 128'(1));
      check_eq("mem_valid cycles", 128'(mem_cycles_total - mem_at_start), 128'(0));
    end
    for (int b = 0; b < 4; b++) begin
      if (we && strb[b]) begin
        model[slot(addr)][8*b +: 8] = wdata[8*b +: 8];
      end
    end
    touched[line_no] = 1'b1;
    prev_line = line_no;
  endtask

  // memory port monitor, mid-cycle
  always @(negedge clk) begin
    if (rst_n && mem_valid) begin
      mem_cycles_total = mem_cycles_total + 1;
      if (!xfer_active) begin
        xfer_active = 1'b1;
        start_req = mem_req;
        check_eq("mem_req.addr[3:0]", 128'(mem_req.addr[offset_bits-1:0]), 128'(0));
      end
      check_eq("mem_req.we", 128'(mem_req.we), 128'(start_req.we));
      check_eq("mem_req.addr", 128'(mem_req.addr), 128'(start_req.addr));
      check_eq("mem_req.line", mem_req.line, start_req.line);
      if (mem_ack) begin
        xfer_active = 1'b0;
        if (mem_req.we) begin
          if (reads_total != reads_at_start) begin
            abort_run("write-back issued after the refill read");
          end
          check_eq("mem_req.line (write-back)", mem_req.line, model_line(mem_req.addr));
        end else begin
          reads_total = reads_total + 1;
          last_read_addr = mem_req.addr;
        end
      end
    end else if (rst_n && xfer_active) begin
      abort_run("mem_valid dropped before mem_ack");
    end
  end

  initial begin
    #(watchdog_ns);
    abort_run("watchdog expired before all requests completed");
  end

  initial begin
    logic [31:0] a;
    int r;
    seed = seed_init;
    rst_n = 1'b0;
    req_valid = 1'b0;
    req = '0;
    for (int i = 0; i < 64; i++) begin
      a = make_addr(i >> 4, (i >> 2) & 3, i & 3);
      model[i] = {2'b00, a[31:2]} ^ fill_key;
    end
    for (int i = 0; i < 16; i++) begin
      touched[i] = 1'b0;
    end
    repeat (3) begin
      @(posedge clk);
      #1;
      check_quiet_outputs();
    end
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_quiet_outputs();
    run_request(1'b0, make_addr(0, 0, 1), 4'h0, '0);  // cold load
    run_request(1'b0, make_addr(0, 0, 1), 4'h0, '0);
    run_request(1'b1, make_addr(1, 2, 3), 4'b0101, 32'hdead_beef);
    run_request(1'b0, make_addr(1, 2, 3), 4'h0, '0);
    repeat (num_txn) begin
      r = $random(seed);
      run_request(r[0], make_addr((r >> 1) & 3, (r >> 3) & 3, (r >> 5) & 3),
                  (r[10:7] == 4'h0) ? 4'hf : r[10:7], word_t'($random(seed)));
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- flist.f
design/cache_geom_pkg.sv
design/cache_bus_pkg.sv
design/sync_ram.sv
design/cpu_front.sv
design/set_store.sv
design/cache_ctrl.sv
design/dcache_top.sv
test/mem_model.sv
test/dcache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --assert --timescale 1ns/100ps --top-module dcache_tb \
  -f flist.f -Mdir "$build_dir" -o dcache_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$build_dir/dcache_sim" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$log"; then
  exit 0
fi
echo "pass line not found in $log"
exit 1
